// File: hw/block_counter.sv
`include "corr_settings.svh"

module block_counter (
   input  logic                clk_i,
   input  logic                sw_d,
   input  logic                run_i,        // Count only while running
   input  logic                strobe_i,
   input  logic [`CORR_CW-1:0] blocksize_i,  // Strobes per block minus one
   output logic                last_o        // Current strobe ends the block
);

   logic [`CORR_CW-1:0] cnt_q;   // Strobes seen in this block

   // ------------------------------
   // Strobe count within a block
   // ------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         cnt_q <= '0;
      end else if (!run_i) begin
         cnt_q <= '0;                      // Restart cleanly after a stop
      end else if (strobe_i) begin
         if (last_o) begin
            cnt_q <= '0;                   // Wrap with the swap
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // Block spans blocksize + 1 strobes, 0 .. blocksize
   assign last_o = (cnt_q == blocksize_i);

   // Blocksize is only rewritten while stopped, so a
   // running count never passes the end of the block
   a_cnt_in_block : assert property (@(posedge clk_i) disable iff (sw_d)
      run_i && $past(run_i) |-> cnt_q <= blocksize_i);

endmodule

// File: hw/corr_accum.sv
`include "corr_settings.svh"

module corr_accum import corr_pkg::*; (
   input  logic                clk_i,
   input  logic                sw_d,
   input  corr_sample_t        sample_i,
   input  logic                run_i,      // Strobes are counted
   input  logic                swap_i,     // Last strobe of the block
   input  logic                bank_i,     // Bank being filled
   input  logic [2:0]          rd_pair_i,  // Bus selected baseline
   input  logic                rd_comp_i,  // 0 real, 1 imaginary
   output logic [`CORR_CW-1:0] rd_data_o   // Frozen bank word
);

   logic [`CORR_ANT-1:0]   re;           // Current signs
   logic [`CORR_ANT-1:0]   im;           // Fake Hilbert, previous signs
   logic [`CORR_ANT-1:0]   hist_q;
   logic [`CORR_PAIRS-1:0] agree_re;     // re_i == re_j per baseline
   logic [`CORR_PAIRS-1:0] agree_im;     // re_i == im_j per baseline
   logic                   frozen;       // Bank held for reading

   // Counters indexed [bank][pair][comp]
   logic [`CORR_CW-1:0] acc_q [2][`CORR_PAIRS][2];

   // ------------------------------
   // Fake Hilbert stage
   // ------------------------------
   // Every strobe updates the history, the priming one too
   always_ff @(posedge clk_i) begin
      if (sample_i.strobe) hist_q <= sample_i.ant;
   end

   assign re     = sample_i.ant;
   assign im     = hist_q;
   assign frozen = ~bank_i;

   // ------------------------------
   // Sign agreement per baseline
   // ------------------------------
   // Pair order 01, 02, 03, 12, 13, 23
   always_comb begin
      int p;
      p        = 0;
      agree_re = '0;
      agree_im = '0;
      for (int i = 0; i < `CORR_ANT; i++) begin
         for (int j = i + 1; j < `CORR_ANT; j++) begin
            agree_re[p] = re[i] ~^ re[j];  // XNOR of signs
            agree_im[p] = re[i] ~^ im[j];
            p++;
         end
      end
   end

   // ------------------------------
   // Accumulator banks
   // ------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         acc_q <= '{default: '0};
      end else begin
         for (int p = 0; p < `CORR_PAIRS; p++) begin
            if (!run_i) begin
               // Stopped, so the filling bank starts the next block empty
               acc_q[bank_i][p][0] <= '0;
               acc_q[bank_i][p][1] <= '0;
            end else if (sample_i.strobe) begin
               // Last strobe still lands in the finishing bank
               acc_q[bank_i][p][0] <= acc_q[bank_i][p][0] + `CORR_CW'(agree_re[p]);
               acc_q[bank_i][p][1] <= acc_q[bank_i][p][1] + `CORR_CW'(agree_im[p]);
            end
            if (swap_i) begin
               acc_q[frozen][p][0] <= '0;  // Becomes the filling bank
               acc_q[frozen][p][1] <= '0;
            end
         end
      end
   end

   // Read port on the frozen bank, spare pairs read zero
   assign rd_data_o = (rd_pair_i < `CORR_PAIRS) ? acc_q[frozen][rd_pair_i][rd_comp_i]
                                                : '0;

endmodule

// File: hw/corr_bus.sv
`include "corr_settings.svh"

module corr_bus import corr_pkg::*; (
   input  logic                clk_i,
   input  logic                sw_d,
   input  logic                stb_i,        // One access per cycle
   input  logic                we_i,
   input  corr_addr_u          adr_i,
   input  logic [`CORR_CW-1:0] dat_i,
   input  logic [`CORR_CW-1:0] rd_data_i,    // Frozen bank word
   input  corr_stat_t          stat_i,
   output logic                ack_o,
   output logic                err_o,
   output logic [`CORR_CW-1:0] dat_o,
   output logic [2:0]          rd_pair_o,
   output logic                rd_comp_o,
   output logic                enable_o,     // CTRL bit 0
   output logic [`CORR_CW-1:0] blocksize_o
);

   logic                vis_hit;   // Valid visibility word
   logic                reg_hit;   // Register unit
   logic                mapped;
   logic [`CORR_CW-1:0] rdata;

   // ------------------------------
   // Address decode
   // ------------------------------
   assign vis_hit = (adr_i.vis.unit == `CORR_UNIT_VIS) && (adr_i.vis.pair < `CORR_PAIRS);
   assign reg_hit = (adr_i.regs.unit == `CORR_UNIT_REG);
   assign mapped  = vis_hit || reg_hit;   // Units 2, 3 and pairs 6, 7 fall out

   // Accumulator select straight from the vis view
   assign rd_pair_o = adr_i.vis.pair;
   assign rd_comp_o = adr_i.vis.comp;

   // Read mux
   always_comb begin
      rdata = '0;
      if (vis_hit) begin
         rdata = rd_data_i;
      end else if (reg_hit) begin
         case (adr_i.regs.regsel)
            `CORR_REG_CTRL:  rdata = {{(`CORR_CW-1){1'b0}}, enable_o};
            `CORR_REG_BSIZE: rdata = blocksize_o;
            `CORR_REG_STAT:  rdata = stat_i;
            default:         rdata = '0;   // Spare slots
         endcase
      end
   end

   // ------------------------------
   // Writable registers
   // ------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         enable_o    <= 1'b0;
         blocksize_o <= '0;
      end else if (stb_i && we_i && reg_hit) begin
         case (adr_i.regs.regsel)
            `CORR_REG_CTRL:  enable_o    <= dat_i[0];
            `CORR_REG_BSIZE: blocksize_o <= dat_i;
            default: ;                     // Status is read-only
         endcase
      end
   end

   // Response, fixed one cycle latency
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
         dat_o <= '0;
      end else begin
         ack_o <= stb_i && mapped;
         err_o <= stb_i && !mapped;
         if (stb_i && !we_i && mapped) dat_o <= rdata;  // Holds otherwise
      end
   end

   a_one_resp : assert property (@(posedge clk_i) disable iff (sw_d)
      !(ack_o && err_o));

endmodule

// File: hw/corr_ctrl.sv
`include "corr_settings.svh"

module corr_ctrl import corr_pkg::*; (
   input  logic                clk_i,
   input  logic                sw_d,
   input  logic                enable_i,   // From control register
   input  logic                strobe_i,   // Sample valid
   input  logic                last_i,     // Final strobe of the block
   output logic                run_o,
   output logic                swap_o,     // Bank swap, same cycle as strobe
   output logic                bank_o,     // Bank being filled
   output logic                switch_o,   // Registered swap
   output logic [`CORR_CW-3:0] blocks_o    // Completed block count
);

   corr_state_e state;

   // ------------------------------
   // Acquisition FSM
   // ------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: if (enable_i) state <= PRIME;
            PRIME: begin
               if (!enable_i) begin
                  state <= IDLE;           // Dropped before any data
               end else if (strobe_i) begin
                  state <= RUN;            // This strobe only fills history
               end
            end
            RUN: if (!enable_i) state <= IDLE;  // Stop, bank is kept
            default: state <= IDLE;
         endcase
      end
   end

   assign run_o  = (state == RUN);
   assign swap_o = run_o && strobe_i && last_i;

   // Bank index, block count and the swap notification
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         bank_o   <= 1'b0;
         switch_o <= 1'b0;
         blocks_o <= '0;
      end else begin
         switch_o <= swap_o;               // One cycle behind the swap
         if (swap_o) begin
            bank_o   <= ~bank_o;
            blocks_o <= blocks_o + 1'b1;   // Wraps
         end
      end
   end

   // Swaps only come out of a running block
   a_swap_in_run : assert property (@(posedge clk_i) disable iff (sw_d)
      swap_o |-> state == RUN && $past(state) != IDLE);

   // The filling bank only moves on a block boundary
   a_bank_on_swap : assert property (@(posedge clk_i) disable iff (sw_d)
      $changed(bank_o) |-> $past(swap_o) && switch_o);

endmodule

// File: hw/corr_pkg.sv
`include "corr_settings.svh"

package corr_pkg;

   // ------------------------------
   // Bus address views
   // ------------------------------
   typedef struct packed {
      logic [1:0] unit;        // Same bits in both views
      logic [2:0] pair;        // Baseline 0..5, 6 and 7 unmapped
      logic       comp;        // 0 real, 1 imaginary
   } corr_vis_adr_t;

   typedef struct packed {
      logic [1:0] unit;
      logic [3:0] regsel;      // Register index
   } corr_reg_adr_t;

   // One address word, read either as a visibility
   // selector or as a register selector
   typedef union packed {
      corr_vis_adr_t vis;
      corr_reg_adr_t regs;
   } corr_addr_u;

   // ------------------------------
   // Sample stream
   // ------------------------------
   typedef struct packed {
      logic                 strobe;  // Antenna bits valid this cycle
      logic [`CORR_ANT-1:0] ant;     // Sign bit per antenna
   } corr_sample_t;

   // Status word, read back through CORR_REG_STAT
   typedef struct packed {
      logic                 running; // Acquisition FSM is in RUN
      logic                 bank;    // Bank currently filling
      logic [`CORR_CW-3:0]  blocks;  // Completed blocks, wraps
   } corr_stat_t;

   // Acquisition FSM states
   typedef enum logic [1:0] {
      IDLE,                    // Stopped
      PRIME,                   // Waiting for a strobe to load Hilbert history
      RUN                      // Counting
   } corr_state_e;

endpackage

// File: hw/corr_top.sv
`include "corr_settings.svh"

module corr_top import corr_pkg::*; (
   input  logic                clk_i,
   input  logic                sw_d,
   input  corr_sample_t        sample_i,   // Strobe plus antenna signs
   input  logic                stb_i,
   input  logic                we_i,
   input  logic [`CORR_AW-1:0] adr_i,
   input  logic [`CORR_CW-1:0] dat_i,
   output logic                ack_o,
   output logic                err_o,
   output logic [`CORR_CW-1:0] dat_o,
   output logic                switch_o    // New frozen bank available
);

   logic                run;
   logic                swap;
   logic                bank;
   logic                last;
   logic                enable;
   logic [`CORR_CW-1:0] blocksize;
   logic [`CORR_CW-3:0] blocks;
   logic [2:0]          rd_pair;
   logic                rd_comp;
   logic [`CORR_CW-1:0] rd_data;
   corr_stat_t          stat;

   // Status word, running is the RUN state of the FSM
   assign stat = '{running: run, bank: bank, blocks: blocks};

   // ------------------------------
   // Control path
   // ------------------------------
   corr_ctrl u_ctrl (
      .clk_i, .sw_d, .enable_i(enable), .strobe_i(sample_i.strobe),
      .last_i(last), .run_o(run), .swap_o(swap), .bank_o(bank),
      .switch_o, .blocks_o(blocks)
   );

   block_counter u_blk (
      .clk_i, .sw_d, .run_i(run), .strobe_i(sample_i.strobe),
      .blocksize_i(blocksize), .last_o(last)
   );

   // ------------------------------
   // Data path
   // ------------------------------
   corr_accum u_accum (
      .clk_i, .sw_d, .sample_i, .run_i(run), .swap_i(swap), .bank_i(bank),
      .rd_pair_i(rd_pair), .rd_comp_i(rd_comp), .rd_data_o(rd_data)
   );

   corr_bus u_bus (
      .clk_i, .sw_d, .stb_i, .we_i, .adr_i, .dat_i, .rd_data_i(rd_data),
      .stat_i(stat), .ack_o, .err_o, .dat_o, .rd_pair_o(rd_pair),
      .rd_comp_o(rd_comp), .enable_o(enable), .blocksize_o(blocksize)
   );

endmodule

// File: include/corr_settings.svh
`ifndef CORR_SETTINGS_SVH
`define CORR_SETTINGS_SVH

// ------------------------------
// Array geometry
// ------------------------------
`define CORR_ANT   4           // Antennas, one sign bit each
`define CORR_PAIRS 6           // Baselines, ANT*(ANT-1)/2

// Accumulators and bus words share one width
`define CORR_CW    16

// ------------------------------
// Register bus
// ------------------------------
`define CORR_AW    6           // Unit(2) + unit-local select(4)

// Top two address bits pick the unit
`define CORR_UNIT_VIS 0        // Visibility words, pair and comp
`define CORR_UNIT_REG 1        // System registers
// Units 2 and 3 give a bus error

// Register indices inside CORR_UNIT_REG
`define CORR_REG_CTRL  0       // Bit 0 enables acquisition
`define CORR_REG_BSIZE 1       // Blocksize minus one
`define CORR_REG_STAT  2       // Read-only status word

`endif

// File: testbench/tb_corr_top.sv
`include "corr_settings.svh"

module tb_corr_top import corr_pkg::*; ();

   typedef struct packed {
      logic [15:0] bsize;     // Blocksize register value
      logic [7:0]  nblk;      // Complete blocks to run
      logic [7:0]  dens;      // Strobe density in percent
   } case_t;

   localparam logic [5:0] A_CTRL  = {2'(`CORR_UNIT_REG), 4'(`CORR_REG_CTRL)};
   localparam logic [5:0] A_BSIZE = {2'(`CORR_UNIT_REG), 4'(`CORR_REG_BSIZE)};
   localparam logic [5:0] A_STAT  = {2'(`CORR_UNIT_REG), 4'(`CORR_REG_STAT)};

   case_t cases [3] = '{'{16'd31, 8'd3, 8'd100}, '{16'd47, 8'd3, 8'd60},
                        '{16'd63, 8'd2, 8'd75}};

   logic                clk_i = 1'b0;
   logic                sw_d;
   corr_sample_t        sample_i;
   logic                stb_i;
   logic                we_i;
   logic [`CORR_AW-1:0] adr_i;
   logic [`CORR_CW-1:0] dat_i;
   logic                ack_o;
   logic                err_o;
   logic [`CORR_CW-1:0] dat_o;
   logic                switch_o;

   // ------------------------------
   // Reference model state
   // ------------------------------
   corr_state_e m_state;
   logic        m_en;
   logic        m_bank;              // Filling bank, the other one is frozen
   logic [15:0] m_bsize;
   logic [15:0] m_cnt;
   logic [13:0] m_blocks;
   logic [3:0]  m_hist;              // Previous strobe, imaginary parts
   logic [15:0] m_acc [2][6][2];     // [bank][pair][comp]

   logic        p_strobe, p_stb, p_we;     // Inputs seen at the coming edge
   logic [3:0]  p_ant;
   logic [5:0]  p_adr;
   logic [15:0] p_dat;
   logic        exp_ack, exp_err, exp_switch;
   logic [15:0] exp_dat;
   logic [22:0] busq [$];            // Pending accesses {we, adr, dat}
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          switches = 0;
   int          limit = 1000;

   corr_top DUT (
      .clk_i, .sw_d, .sample_i, .stb_i, .we_i, .adr_i, .dat_i,
      .ack_o, .err_o, .dat_o, .switch_o
   );

   always #10 clk_i = ~clk_i;

   // Watchdog
   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("Timeout after %0d cycles, test sequence did not complete", cycles);
         $display(">>> FAIL");
         $finish;
      end
   end

   task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error %s: got %h, expected %h (cycle %0d)", name, got, exp, cycles);
      end
   endtask

   function automatic logic mapped(input logic [5:0] adr);
      return (adr[5:4] == `CORR_UNIT_VIS && adr[3:1] < `CORR_PAIRS) ||
             adr[5:4] == `CORR_UNIT_REG;
   endfunction

   function automatic logic [15:0] model_read(input logic [5:0] adr);
      if (adr[5:4] == `CORR_UNIT_VIS) return m_acc[~m_bank][adr[3:1]][adr[0]];
      case (adr[3:0])
         `CORR_REG_CTRL:  return {15'd0, m_en};
         `CORR_REG_BSIZE: return m_bsize;
         `CORR_REG_STAT:  return {m_state == RUN, m_bank, m_blocks};
         default:         return '0;   // Spare register slots
      endcase
   endfunction

   task automatic bus_write(input logic [5:0] adr, input logic [15:0] dat);
      busq.push_back({1'b1, adr, dat});
   endtask

   task automatic bus_read(input logic [5:0] adr);
      busq.push_back({1'b0, adr, 16'h0});
   endtask

   // Status plus all 12 visibility words of the frozen bank
   task automatic read_block();
      bus_read(A_STAT);
      for (int a = 0; a < 2 * `CORR_PAIRS; a++) bus_read(6'(a));
   endtask

   // One clock edge of the model, from the inputs seen before the edge
   task automatic model_edge();
      int p;
      exp_switch = (m_state == RUN) && p_strobe && (m_cnt == m_bsize);
      exp_ack    = p_stb && mapped(p_adr);
      exp_err    = p_stb && !mapped(p_adr);
      if (p_stb && !p_we && mapped(p_adr)) exp_dat = model_read(p_adr);
      p = 0;
      for (int i = 0; i < `CORR_ANT; i++) begin
         for (int j = i + 1; j < `CORR_ANT; j++) begin
            if (m_state != RUN) begin
               m_acc[m_bank][p][0] = '0;      // Filling bank idles empty
               m_acc[m_bank][p][1] = '0;
            end else if (p_strobe) begin
               m_acc[m_bank][p][0] += 16'(p_ant[i] == p_ant[j]);
               m_acc[m_bank][p][1] += 16'(p_ant[i] == m_hist[j]);
            end
            if (exp_switch) begin
               m_acc[~m_bank][p][0] = '0;
               m_acc[~m_bank][p][1] = '0;
            end
            p++;
         end
      end
      if (m_state != RUN) m_cnt = '0;
      else if (p_strobe) m_cnt = exp_switch ? 16'd0 : m_cnt + 16'd1;
      if (exp_switch) begin
         m_bank   = ~m_bank;
         m_blocks = m_blocks + 14'd1;
      end
      case (m_state)
         IDLE:    if (m_en) m_state = PRIME;
         PRIME:   if (!m_en) m_state = IDLE; else if (p_strobe) m_state = RUN;
         default: if (!m_en) m_state = IDLE;
      endcase
      if (p_strobe) m_hist = p_ant;
      if (p_stb && p_we && p_adr[5:4] == `CORR_UNIT_REG) begin
         if (p_adr[3:0] == `CORR_REG_CTRL) m_en = p_dat[0];
         if (p_adr[3:0] == `CORR_REG_BSIZE) m_bsize = p_dat;
      end
   endtask

   // ------------------------------
   // One cycle of stimulus and checks
   // ------------------------------
   task automatic cycle(input int dens);
      logic [22:0] acc;
      @(posedge clk_i);
      model_edge();
      if (exp_switch) read_block();   // Reads go out during the next block
      p_strobe = (dens > 0) && (($urandom % 100) < dens);
      p_ant    = 4'($urandom);
      p_stb    = busq.size() != 0;
      p_we     = 1'b0;
      if (p_stb) begin
         acc = busq.pop_front();
         {p_we, p_adr, p_dat} = acc;
      end
      sample_i <= '{strobe: p_strobe, ant: p_ant};
      stb_i    <= p_stb;
      we_i     <= p_we;
      adr_i    <= p_adr;
      dat_i    <= p_dat;
      @(negedge clk_i);
      check("ack_o", ack_o, exp_ack);
      check("err_o", err_o, exp_err);
      check("dat_o", dat_o, exp_dat);
      check("switch_o", switch_o, exp_switch);
      if (switch_o === 1'b1) switches++;
   endtask

   task automatic drain(input int dens);
      while (busq.size() != 0) cycle(dens);
      cycle(dens);                      // Response to the last access
   endtask

   initial begin
      logic [13:0] target;
      void'($urandom(32'h670c));
      foreach (cases[c]) limit += 4 * (cases[c].bsize + 1) * cases[c].nblk;
      sw_d = 1'b1;
      sample_i = '0;
      stb_i = 1'b0;
      we_i = 1'b0;
      adr_i = '0;
      dat_i = '0;
      {p_strobe, p_stb, p_we, p_ant, p_adr, p_dat} = '0;
      {exp_ack, exp_err, exp_switch, exp_dat} = '0;
      {m_en, m_bank, m_bsize, m_cnt, m_blocks, m_hist} = '0;
      m_state = IDLE;
      m_acc = '{default: '0};
      repeat (5) @(posedge clk_i);
      sw_d <= 1'b0;

      // Reset values of registers and visibilities
      bus_read(A_CTRL);
      bus_read(A_BSIZE);
      read_block();
      drain(0);

      // Register write and read-only status, then unmapped accesses
      bus_write(A_BSIZE, 16'ha5c3);
      bus_read(A_BSIZE);
      bus_write(A_STAT, 16'hffff);
      bus_read(A_STAT);
      bus_write(6'h01, 16'h1234);        // Vis write is ignored
      bus_read(6'h01);
      bus_read({2'd2, 4'h3});
      bus_write({2'd3, 4'h0}, 16'h0001);
      bus_read({2'd0, 3'd6, 1'b0});
      bus_read({2'd0, 3'd7, 1'b1});
      drain(0);

      // Block runs, each ending with a stop part way into a block
      foreach (cases[c]) begin
         bus_write(A_BSIZE, cases[c].bsize);
         bus_write(A_CTRL, 16'h0001);
         target = m_blocks + 14'(cases[c].nblk);
         while (m_blocks != target || busq.size() != 0) cycle(cases[c].dens);
         repeat (cases[c].bsize / 2) cycle(cases[c].dens);
         bus_write(A_CTRL, 16'h0000);
         drain(cases[c].dens);
         read_block();                   // Frozen bank survives the stop
         drain(cases[c].dens);
      end
      check("switch_o count", 16'(switches), 16'(m_blocks));

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+include
hw/corr_pkg.sv
hw/corr_ctrl.sv
hw/block_counter.sv
hw/corr_accum.sv
hw/corr_bus.sv
hw/corr_top.sv
testbench/tb_corr_top.sv
